//--- hw/ifu_pkg.sv
// Shared types, fetch FSM states and predictor constants for the fetch unit
package ifu_pkg;

   // **************************************************
   // Address and data widths
   // **************************************************
   typedef logic [30:0] pc_t;            // Halfword pc, address bits 31:1
   typedef logic [29:0] word_addr_t;     // Fetch word address, bits 31:2
   typedef logic [31:0] fetch_word_t;    // One ICCM word, two parcels
   typedef logic [15:0] parcel_t;        // 16-bit instruction parcel
   typedef logic [31:0] instr_t;         // Instr to decode, RVC zero-extended

   // **************************************************
   // Branch prediction
   // **************************************************
   typedef logic [1:0]  bht_ctr_t;       // 2-bit saturating direction counter

   localparam bht_ctr_t BHT_STRONG_NT  = 2'b00;   // Floor of the counter
   localparam bht_ctr_t BHT_WEAK_TAKEN = 2'b10;   // Value on allocation
   localparam bht_ctr_t BHT_STRONG_T   = 2'b11;   // Ceiling of the counter

   // Fetch FSM
   typedef enum logic {
      FETCH_RUN  = 1'b0,                 // Issue reads while buffer has room
      FETCH_HALT = 1'b1                  // Parked until a redirecting flush
   } fetch_state_t;

   // Low two bits both set mark a 4-byte encoding
   function automatic logic is_4byte(input parcel_t p);
      return &p[1:0];
   endfunction

endpackage

//--- hw/ifu_fetch_ctl.sv
// Fetch controller that tracks the next word address and drives ICCM reads
module ifu_fetch_ctl
   import ifu_pkg::*;
#(
   parameter logic [31:0] RST_VEC = 32'h0000_0000
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       exu_flush_final,          // Flush strobe
   input  pc_t        exu_flush_path_final,     // Flush target
   input  logic       dec_tlu_flush_noredir_wb, // Flush parks fetch
   input  logic       bp_hit_taken_f,           // Predicted taken in F
   input  pc_t        bp_target_f,              // Predicted target in F
   input  logic       buf_room,                 // Aligner can take two words
   output logic       fetch_req_bf,             // Lookup strobe to predictor
   output word_addr_t fetch_addr_bf,            // Lookup address to predictor
   output logic       fetch_valid_f,            // Read data is usable
   output word_addr_t fetch_addr_f,             // Address of read data
   output logic       iccm_rden,                // ICCM read strobe
   output word_addr_t iccm_rw_addr              // ICCM word address
);

   fetch_state_t state_q, state_d;               // Run/halt FSM
   word_addr_t   addr_q, addr_d;                 // Next fetch address
   logic         fetch_req_f;                    // Read was issued last cycle
   logic         kill_f;                         // Read behind a taken branch
   logic         taken_f;                        // Qualified prediction

   // **************************************************
   // BF stage
   // **************************************************
   assign fetch_req_bf  = rst_n & (state_q == FETCH_RUN) & buf_room & ~exu_flush_final;
   assign fetch_addr_bf = addr_q;
   assign iccm_rden     = fetch_req_bf;
   assign iccm_rw_addr  = addr_q;

   // Only a live word may redirect
   assign taken_f       = bp_hit_taken_f & fetch_valid_f;
   assign fetch_valid_f = fetch_req_f & ~kill_f & ~exu_flush_final;

   always_comb begin
      addr_d = addr_q;
      if (exu_flush_final) begin
         addr_d = exu_flush_path_final[30:1];    // Flush wins
      end else if (taken_f) begin
         addr_d = bp_target_f[30:1];             // Then predicted target
      end else if (fetch_req_bf) begin
         addr_d = addr_q + 30'd1;                // Else next word
      end
   end

   always_comb begin
      state_d = state_q;
      if (exu_flush_final) begin
         state_d = dec_tlu_flush_noredir_wb ? FETCH_HALT : FETCH_RUN;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q     <= FETCH_RUN;
         addr_q      <= RST_VEC[31:2];           // First read right after reset
         fetch_req_f <= 1'b0;
         kill_f      <= 1'b0;
      end else begin
         state_q     <= state_d;
         addr_q      <= addr_d;
         fetch_req_f <= fetch_req_bf;
         kill_f      <= taken_f;                 // Drop the sequential read
      end
   end

   // F stage address follows the read
   always_ff @(posedge clk) begin
      fetch_addr_f <= addr_q;
   end

   // Flush path is the next word put on the ICCM port
   a_flush_addr: assert property (@(posedge clk) disable iff (!rst_n)
      exu_flush_final |=> (iccm_rw_addr == $past(exu_flush_path_final[30:1])));

endmodule

//--- hw/ifu_bp_ctl.sv
// Direct-mapped BTB with 2-bit counters, looked up at fetch and trained at retire
module ifu_bp_ctl
   import ifu_pkg::*;
#(
   parameter int BTB_INDEX_BITS = 4
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       fetch_req_bf,          // Lookup strobe
   input  word_addr_t fetch_addr_bf,         // Lookup word address
   input  logic       dec_tlu_bpred_disable,
   input  logic       exu_flush_final,
   input  logic       br_upd_valid,          // Retire update strobe
   input  pc_t        br_upd_pc,
   input  logic       br_upd_pc4,
   input  logic       br_upd_taken,
   input  pc_t        br_upd_target,
   output logic       bp_hit_taken_f,        // Redirect fetch
   output pc_t        bp_target_f,
   output logic       bp_offset_f            // Halfword of the branch
);

   localparam int DEPTH = 1 << BTB_INDEX_BITS;
   localparam int TAG_W = 30 - BTB_INDEX_BITS;

   // **************************************************
   // Entry storage
   // **************************************************
   logic [DEPTH-1:0]          vld_q;
   logic [TAG_W-1:0]          tag_q [DEPTH];
   logic [DEPTH-1:0]          off_q;
   pc_t                       tgt_q [DEPTH];
   bht_ctr_t                  ctr_q [DEPTH];

   logic [BTB_INDEX_BITS-1:0] rd_idx_f;      // Flopped lookup index
   logic [TAG_W-1:0]          rd_tag_f;
   logic                      req_f;
   logic                      dis_f;         // Disable sampled with lookup
   logic                      rd_hit_f;

   word_addr_t                upd_waddr;
   logic [BTB_INDEX_BITS-1:0] upd_idx;
   logic [TAG_W-1:0]          upd_tag;
   logic                      upd_hit;
   logic                      upd_alloc;

   // Lookup, one cycle in step with the ICCM
   always_ff @(posedge clk) begin
      rd_idx_f <= fetch_addr_bf[BTB_INDEX_BITS-1:0];
      rd_tag_f <= fetch_addr_bf[29:BTB_INDEX_BITS];
   end

   assign rd_hit_f       = req_f & vld_q[rd_idx_f] & (tag_q[rd_idx_f] == rd_tag_f);
   assign bp_hit_taken_f = rd_hit_f & ctr_q[rd_idx_f][1] & ~dis_f & ~exu_flush_final;
   assign bp_target_f    = tgt_q[rd_idx_f];
   assign bp_offset_f    = off_q[rd_idx_f];

   // **************************************************
   // Retire update
   // **************************************************
   assign upd_waddr = br_upd_pc[30:1];
   assign upd_idx   = upd_waddr[BTB_INDEX_BITS-1:0];
   assign upd_tag   = upd_waddr[29:BTB_INDEX_BITS];
   assign upd_hit   = vld_q[upd_idx] & (tag_q[upd_idx] == upd_tag) &
                      (off_q[upd_idx] == br_upd_pc[0]);
   // A 4-byte branch in the upper half spans two words
   assign upd_alloc = ~upd_hit & br_upd_taken & ~(br_upd_pc4 & br_upd_pc[0]);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_f <= 1'b0;
         dis_f <= 1'b0;
         vld_q <= '0;
         off_q <= '0;
         for (int i = 0; i < DEPTH; i++) begin
            tag_q[i] <= '0;
            tgt_q[i] <= '0;
            ctr_q[i] <= BHT_STRONG_NT;
         end
      end else begin
         req_f <= fetch_req_bf;
         dis_f <= dec_tlu_bpred_disable;
         if (br_upd_valid && upd_hit) begin
            if (br_upd_taken) begin
               if (ctr_q[upd_idx] != BHT_STRONG_T) begin
                  ctr_q[upd_idx] <= ctr_q[upd_idx] + 2'd1;   // Count up
               end
               tgt_q[upd_idx] <= br_upd_target;              // Latest target
            end else if (ctr_q[upd_idx] != BHT_STRONG_NT) begin
               ctr_q[upd_idx] <= ctr_q[upd_idx] - 2'd1;      // Count down
            end
         end else if (br_upd_valid && upd_alloc) begin
            vld_q[upd_idx] <= 1'b1;                          // New entry
            tag_q[upd_idx] <= upd_tag;
            off_q[upd_idx] <= br_upd_pc[0];
            tgt_q[upd_idx] <= br_upd_target;
            ctr_q[upd_idx] <= BHT_WEAK_TAKEN;
         end
      end
   end

   // Taken update on a hit never wraps the counter to the floor
   a_ctr_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
      br_upd_valid && br_upd_taken && upd_hit |=>
         (ctr_q[$past(upd_idx)] != BHT_STRONG_NT));

endmodule

//--- hw/ifu_aln_ctl.sv
// Aligner that buffers fetch parcels and hands 16-bit and 32-bit instructions to decode
module ifu_aln_ctl
   import ifu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        fetch_valid_f,          // Word arrives
   input  word_addr_t  fetch_addr_f,
   input  fetch_word_t iccm_rd_data,
   input  logic        bp_hit_taken_f,
   input  pc_t         bp_target_f,
   input  logic        bp_offset_f,
   input  logic        exu_flush_final,
   input  pc_t         exu_flush_path_final,
   input  logic        dec_i0_decode_d,        // Decode takes head instr
   output logic        buf_room,               // Two words free
   output logic        ifu_i0_valid,
   output instr_t      ifu_i0_instr,
   output pc_t         ifu_i0_pc,
   output logic        ifu_i0_pc4,
   output logic        ifu_i0_bp_taken,
   output pc_t         ifu_i0_bp_target
);

   parcel_t    buf_q  [8];                      // Parcel ring
   logic [7:0] mark_q;                         // Taken branch ends here
   pc_t        tgt_q  [8];                      // Target of marked parcel
   logic [3:0] cnt_q;                          // Parcels held, 0..8
   logic [2:0] rd_ptr_q, wr_ptr_q;
   logic [2:0] rd_ptr1, hi_ptr;
   pc_t        pc_q;                           // Pc of head parcel
   logic       skip_lo_q;                      // Entry at odd halfword

   logic       head_is4, head_mark, pop;
   pc_t        head_tgt;
   logic [1:0] need, pop_n, wr_n;
   logic       taken, end_hi, wr_lo, wr_hi;

   // **************************************************
   // Write side
   // **************************************************
   assign taken  = fetch_valid_f & bp_hit_taken_f;
   // Branch ends high if it starts high or is a 4-byte at the low half
   assign end_hi = bp_offset_f | is_4byte(iccm_rd_data[15:0]);
   assign wr_lo  = fetch_valid_f & ~skip_lo_q;
   assign wr_hi  = fetch_valid_f & ~(taken & ~end_hi);  // Nothing past the branch
   assign wr_n   = 2'(wr_lo) + 2'(wr_hi);
   assign hi_ptr = wr_ptr_q + 3'(wr_lo);

   always_ff @(posedge clk) begin
      if (wr_lo) begin
         buf_q[wr_ptr_q]  <= iccm_rd_data[15:0];
         mark_q[wr_ptr_q] <= taken & ~end_hi;
         tgt_q[wr_ptr_q]  <= bp_target_f;
      end
      if (wr_hi) begin
         buf_q[hi_ptr]    <= iccm_rd_data[31:16];
         mark_q[hi_ptr]   <= taken & end_hi;
         tgt_q[hi_ptr]    <= bp_target_f;
      end
   end

   // **************************************************
   // Head instruction
   // **************************************************
   assign rd_ptr1   = rd_ptr_q + 3'd1;
   assign head_is4  = is_4byte(buf_q[rd_ptr_q]);
   assign need      = head_is4 ? 2'd2 : 2'd1;
   assign head_mark = head_is4 ? mark_q[rd_ptr1] : mark_q[rd_ptr_q];
   assign head_tgt  = head_is4 ? tgt_q[rd_ptr1] : tgt_q[rd_ptr_q];

   assign ifu_i0_valid     = (cnt_q != 4'd0) & (~head_is4 | (cnt_q >= 4'd2));
   assign ifu_i0_instr     = head_is4 ? {buf_q[rd_ptr1], buf_q[rd_ptr_q]} :
                                        {16'h0000, buf_q[rd_ptr_q]};
   assign ifu_i0_pc        = pc_q;
   assign ifu_i0_pc4       = head_is4;
   assign ifu_i0_bp_taken  = ifu_i0_valid & head_mark;
   assign ifu_i0_bp_target = head_tgt;

   assign pop      = ifu_i0_valid & dec_i0_decode_d;
   assign pop_n    = pop ? need : 2'd0;
   assign buf_room = (cnt_q <= 4'd4);          // One read may still be in flight

   // Ring pointers and fill level
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt_q     <= 4'd0;
         rd_ptr_q  <= 3'd0;
         wr_ptr_q  <= 3'd0;
         skip_lo_q <= 1'b0;
      end else if (exu_flush_final) begin
         cnt_q     <= 4'd0;                    // Drop everything
         rd_ptr_q  <= 3'd0;
         wr_ptr_q  <= 3'd0;
         skip_lo_q <= exu_flush_path_final[0];
      end else begin
         cnt_q    <= cnt_q - 4'(pop_n) + 4'(wr_n);
         rd_ptr_q <= rd_ptr_q + 3'(pop_n);
         wr_ptr_q <= wr_ptr_q + 3'(wr_n);
         if (fetch_valid_f) begin
            skip_lo_q <= taken & bp_target_f[0];   // Odd target word next
         end
      end
   end

   // Head pc steps with pops, reloads when a word lands in an empty ring
   always_ff @(posedge clk) begin
      if (pop) begin
         pc_q <= head_mark ? head_tgt : pc_q + 31'(need);
      end
      if (fetch_valid_f && (cnt_q == 4'(pop_n))) begin
         pc_q <= {fetch_addr_f, skip_lo_q};
      end
   end

   // Stalled head holds its pc until a flush
   a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_i0_valid && !dec_i0_decode_d && !exu_flush_final |=> $stable(ifu_i0_pc));

endmodule

//--- hw/ifu.sv
// Instruction fetch unit top level joining fetch control, branch predictor and aligner
module ifu
   import ifu_pkg::*;
#(
   parameter int          BTB_INDEX_BITS = 4,
   parameter logic [31:0] RST_VEC        = 32'h0000_0000
) (
   input  logic        clk,
   input  logic        rst_n,
   // Flush and decode
   input  logic        exu_flush_final,
   input  pc_t         exu_flush_path_final,
   input  logic        dec_tlu_flush_noredir_wb,
   input  logic        dec_i0_decode_d,
   input  logic        dec_tlu_bpred_disable,
   // Retire update
   input  logic        br_upd_valid,
   input  pc_t         br_upd_pc,
   input  logic        br_upd_pc4,
   input  logic        br_upd_taken,
   input  pc_t         br_upd_target,
   // ICCM port
   output logic        iccm_rden,
   output word_addr_t  iccm_rw_addr,
   input  fetch_word_t iccm_rd_data,
   // To decode
   output logic        ifu_i0_valid,
   output instr_t      ifu_i0_instr,
   output pc_t         ifu_i0_pc,
   output logic        ifu_i0_pc4,
   output logic        ifu_i0_bp_taken,
   output pc_t         ifu_i0_bp_target
);

   // **************************************************
   // Internal nets
   // **************************************************
   logic       fetch_req_bf;
   word_addr_t fetch_addr_bf;
   logic       fetch_valid_f;
   word_addr_t fetch_addr_f;
   logic       bp_hit_taken_f;
   pc_t        bp_target_f;
   logic       bp_offset_f;
   logic       buf_room;

   // Fetch control
   ifu_fetch_ctl #(
      .RST_VEC (RST_VEC)
   ) i_fetch_ctl (
      .clk                      (clk),
      .rst_n                    (rst_n),
      .exu_flush_final          (exu_flush_final),
      .exu_flush_path_final     (exu_flush_path_final),
      .dec_tlu_flush_noredir_wb (dec_tlu_flush_noredir_wb),
      .bp_hit_taken_f           (bp_hit_taken_f),
      .bp_target_f              (bp_target_f),
      .buf_room                 (buf_room),
      .fetch_req_bf             (fetch_req_bf),
      .fetch_addr_bf            (fetch_addr_bf),
      .fetch_valid_f            (fetch_valid_f),
      .fetch_addr_f             (fetch_addr_f),
      .iccm_rden                (iccm_rden),
      .iccm_rw_addr             (iccm_rw_addr)
   );

   // Branch predictor
   ifu_bp_ctl #(
      .BTB_INDEX_BITS (BTB_INDEX_BITS)
   ) i_bp_ctl (
      .clk                   (clk),
      .rst_n                 (rst_n),
      .fetch_req_bf          (fetch_req_bf),
      .fetch_addr_bf         (fetch_addr_bf),
      .dec_tlu_bpred_disable (dec_tlu_bpred_disable),
      .exu_flush_final       (exu_flush_final),
      .br_upd_valid          (br_upd_valid),
      .br_upd_pc             (br_upd_pc),
      .br_upd_pc4            (br_upd_pc4),
      .br_upd_taken          (br_upd_taken),
      .br_upd_target         (br_upd_target),
      .bp_hit_taken_f        (bp_hit_taken_f),
      .bp_target_f           (bp_target_f),
      .bp_offset_f           (bp_offset_f)
   );

   // Aligner
   ifu_aln_ctl i_aln_ctl (
      .clk                  (clk),
      .rst_n                (rst_n),
      .fetch_valid_f        (fetch_valid_f),
      .fetch_addr_f         (fetch_addr_f),
      .iccm_rd_data         (iccm_rd_data),
      .bp_hit_taken_f       (bp_hit_taken_f),
      .bp_target_f          (bp_target_f),
      .bp_offset_f          (bp_offset_f),
      .exu_flush_final      (exu_flush_final),
      .exu_flush_path_final (exu_flush_path_final),
      .dec_i0_decode_d      (dec_i0_decode_d),
      .buf_room             (buf_room),
      .ifu_i0_valid         (ifu_i0_valid),
      .ifu_i0_instr         (ifu_i0_instr),
      .ifu_i0_pc            (ifu_i0_pc),
      .ifu_i0_pc4           (ifu_i0_pc4),
      .ifu_i0_bp_taken      (ifu_i0_bp_taken),
      .ifu_i0_bp_target     (ifu_i0_bp_target)
   );

endmodule

//--- dv/ifu_clk_gen.sv
// Clock and reset source for the fetch unit testbench
module ifu_clk_gen #(
   parameter int PERIOD_NS  = 4,
   parameter int RST_CYCLES = 8
) (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;    // Free running
   end

   initial begin
      rst_n = 1'b0;                            // Held from time zero
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);                          // Release away from the sampling edge
      rst_n = 1'b1;
   end

endmodule

//--- dv/ifu_tb_mem.sv
// Program memory model for the ICCM port with a fixed one-cycle read latency
module ifu_tb_mem
   import ifu_pkg::*;
#(
   parameter int AW = 8                        // Word address bits kept
) (
   input  logic        clk,
   input  logic        rden,                   // Read strobe from fetch
   input  word_addr_t  addr,                   // Word address
   output fetch_word_t rd_data                 // Valid the cycle after rden
);
   timeunit 1ns;
   timeprecision 100ps;

   // **************************************************
   // Storage
   // **************************************************
   fetch_word_t mem [1 << AW];                 // Program image, loaded at time zero

   // Upper address bits fold onto the same image
   always_ff @(posedge clk) begin
      if (rden) begin
         rd_data <= mem[addr[AW-1:0]];
      end
   end

endmodule

//--- dv/ifu_tb.sv
// Testbench for the fetch unit with a random program, a BTB model and in-order stream checks
module ifu_tb
   import ifu_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          BTB_INDEX_BITS = 4;
   localparam logic [31:0] RST_VEC        = 32'h0000_0200;
   localparam int          MEM_AW         = 8;       // 256 program words
   localparam int          BTB_DEPTH      = 1 << BTB_INDEX_BITS;
   localparam int          TIMEOUT        = 200;     // Cycles without an accept
   localparam int          RST_CYCLES     = 8;

   logic        clk;
   logic        rst_n;
   logic        exu_flush_final;
   pc_t         exu_flush_path_final;
   logic        dec_tlu_flush_noredir_wb;
   logic        dec_i0_decode_d;
   logic        dec_tlu_bpred_disable;
   logic        br_upd_valid;
   pc_t         br_upd_pc;
   logic        br_upd_pc4;
   logic        br_upd_taken;
   pc_t         br_upd_target;
   logic        iccm_rden;
   word_addr_t  iccm_rw_addr;
   fetch_word_t iccm_rd_data;
   logic        ifu_i0_valid;
   instr_t      ifu_i0_instr;
   pc_t         ifu_i0_pc;
   logic        ifu_i0_pc4;
   logic        ifu_i0_bp_taken;
   pc_t         ifu_i0_bp_target;

   // **************************************************
   // Model state
   // **************************************************
   logic [31:0] lfsr_q;                         // Random source
   fetch_word_t prog [1 << MEM_AW];             // Program image copy
   pc_t         mdl_pc;                         // Next expected pc
   logic        m_vld  [BTB_DEPTH];
   word_addr_t  m_word [BTB_DEPTH];             // Full word address as tag
   logic        m_off  [BTB_DEPTH];
   pc_t         m_tgt  [BTB_DEPTH];
   bht_ctr_t    m_ctr  [BTB_DEPTH];
   int          taken_seen;                     // Accepted predicted branches

   ifu_clk_gen #(.PERIOD_NS(4), .RST_CYCLES(RST_CYCLES)) i_clk_gen (.clk(clk), .rst_n(rst_n));

   ifu_tb_mem #(.AW(MEM_AW)) i_mem (
      .clk     (clk),
      .rden    (iccm_rden),
      .addr    (iccm_rw_addr),
      .rd_data (iccm_rd_data)
   );

   ifu #(.BTB_INDEX_BITS(BTB_INDEX_BITS), .RST_VEC(RST_VEC)) i_ifu (.*);

   // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_pc(input string name, input pc_t got, input pc_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                 $time, name, got, exp));
      end
   endtask

   task automatic check_instr(input string name, input instr_t got, input instr_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                 $time, name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                                 $time, name, got, exp));
      end
   endtask

   // **************************************************
   // Reference model
   // **************************************************
   function automatic parcel_t parcel_at(input pc_t h);
      fetch_word_t w;
      w = prog[h[MEM_AW:1]];                    // Wraps like the memory
      return h[0] ? w[31:16] : w[15:0];
   endfunction

   function automatic logic model_taken(input pc_t h);
      logic [BTB_INDEX_BITS-1:0] idx;
      idx = h[BTB_INDEX_BITS:1];
      return !dec_tlu_bpred_disable && m_vld[idx] && (m_word[idx] == h[30:1]) &&
             (m_off[idx] == h[0]) && m_ctr[idx][1];
   endfunction

   task automatic model_update(input pc_t pc, input logic pc4, input logic taken, input pc_t tgt);
      logic [BTB_INDEX_BITS-1:0] idx;
      idx = pc[BTB_INDEX_BITS:1];
      if (m_vld[idx] && (m_word[idx] == pc[30:1]) && (m_off[idx] == pc[0])) begin
         if (taken) begin
            m_tgt[idx] = tgt;
            if (m_ctr[idx] != 2'b11) begin
               m_ctr[idx] = m_ctr[idx] + 2'd1;  // Saturate up
            end
         end else if (m_ctr[idx] != 2'b00) begin
            m_ctr[idx] = m_ctr[idx] - 2'd1;     // Saturate down
         end
      end else if (taken && !(pc4 && pc[0])) begin
         m_vld[idx]  = 1'b1;                    // Allocate on taken miss
         m_word[idx] = pc[30:1];
         m_off[idx]  = pc[0];
         m_tgt[idx]  = tgt;
         m_ctr[idx]  = BHT_WEAK_TAKEN;
      end
   endtask

   // Compare the presented head with the model, step the model on accept
   task automatic check_head(input logic accept);
      parcel_t lo;
      logic    is4;
      logic    tkn;
      instr_t  exp;
      lo  = parcel_at(mdl_pc);
      is4 = is_4byte(lo);
      tkn = model_taken(mdl_pc);
      exp = is4 ? {parcel_at(mdl_pc + 31'd1), lo} : {16'h0000, lo};
      check_pc("ifu_i0_pc", ifu_i0_pc, mdl_pc);
      check_instr("ifu_i0_instr", ifu_i0_instr, exp);
      check_flag("ifu_i0_pc4", ifu_i0_pc4, is4);
      check_flag("ifu_i0_bp_taken", ifu_i0_bp_taken, tkn);
      if (tkn) begin
         check_pc("ifu_i0_bp_target", ifu_i0_bp_target, m_tgt[mdl_pc[BTB_INDEX_BITS:1]]);
      end
      if (accept) begin
         taken_seen = taken_seen + int'(tkn);
         mdl_pc     = tkn ? m_tgt[mdl_pc[BTB_INDEX_BITS:1]] : mdl_pc + (is4 ? 31'd2 : 31'd1);
      end
   endtask

   // **************************************************
   // Stimulus tasks
   // **************************************************
   // Decode accepts with chance (4 - stall_lvl) / 4 per cycle
   task automatic run_stream(input int n_instr, input int stall_lvl);
      int     accepted;
      int     idle;
      logic   go;
      logic   held;
      pc_t    held_pc;
      instr_t held_instr;
      accepted = 0;
      idle     = 0;
      held     = 1'b0;
      while (accepted < n_instr) begin
         @(negedge clk);
         if (held) begin                        // Stalled head must not move
            check_flag("ifu_i0_valid", ifu_i0_valid, 1'b1);
            check_pc("ifu_i0_pc", ifu_i0_pc, held_pc);
            check_instr("ifu_i0_instr", ifu_i0_instr, held_instr);
         end
         go              = (int'(rand_bits(2)) >= stall_lvl);
         dec_i0_decode_d = go;
         held            = ifu_i0_valid & ~go;
         held_pc         = ifu_i0_pc;
         held_instr      = ifu_i0_instr;
         if (ifu_i0_valid) begin
            check_head(go);
         end
         if (ifu_i0_valid && go) begin
            accepted = accepted + 1;
            idle     = 0;
         end else begin
            idle = idle + 1;
            if (idle > TIMEOUT) begin
               stop_on_error($sformatf("no instruction accepted for %0d cycles", TIMEOUT));
            end
         end
      end
   endtask

   task automatic flush_to(input pc_t path, input logic noredir);
      @(negedge clk);
      dec_i0_decode_d          = 1'b0;
      exu_flush_final          = 1'b1;
      exu_flush_path_final     = path;
      dec_tlu_flush_noredir_wb = noredir;
      @(negedge clk);
      exu_flush_final          = 1'b0;
      dec_tlu_flush_noredir_wb = 1'b0;
      if (!noredir) begin
         mdl_pc = path;                         // Walk restarts here
      end
   endtask

   // Park fetch, then a quiet window of fixed length
   task automatic halt_quiet(input int cycles);
      flush_to('0, 1'b1);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         check_flag("ifu_i0_valid", ifu_i0_valid, 1'b0);
         check_flag("iccm_rden", iccm_rden, 1'b0);
      end
   endtask

   task automatic retire(input pc_t pc, input logic pc4, input logic taken, input pc_t tgt);
      @(negedge clk);
      br_upd_valid  = 1'b1;
      br_upd_pc     = pc;
      br_upd_pc4    = pc4;
      br_upd_taken  = taken;
      br_upd_target = tgt;
      @(negedge clk);
      br_upd_valid  = 1'b0;
      model_update(pc, pc4, taken, tgt);
   endtask

   // Branch site a few instructions after start, never a 4-byte op at an odd pc
   task automatic pick_branch(input pc_t start, output pc_t site, output logic site4);
      pc_t h;
      int  steps;
      h     = start;
      steps = 1 + int'(rand_bits(2));
      while (steps > 0 || (is_4byte(parcel_at(h)) && h[0])) begin
         h     = h + (is_4byte(parcel_at(h)) ? 31'd2 : 31'd1);
         steps = steps - 1;
         if (steps < -64) begin
            stop_on_error("no usable branch site found after the loop start");
         end
      end
      site  = h;
      site4 = is_4byte(parcel_at(h));
   endtask

   // **************************************************
   // Test sequence
   // **************************************************
   initial begin
      int   wait_cnt;
      pc_t  loop_pc;
      pc_t  site;
      logic site4;
      lfsr_q                   = 32'h12f;
      exu_flush_final          = 1'b0;
      exu_flush_path_final     = '0;
      dec_tlu_flush_noredir_wb = 1'b0;
      dec_i0_decode_d          = 1'b0;
      dec_tlu_bpred_disable    = 1'b1;
      br_upd_valid             = 1'b0;
      br_upd_pc                = '0;
      br_upd_pc4               = 1'b0;
      br_upd_taken             = 1'b0;
      br_upd_target            = '0;
      taken_seen               = 0;
      mdl_pc                   = RST_VEC[31:1];
      for (int i = 0; i < BTB_DEPTH; i++) begin
         m_vld[i] = 1'b0;
         m_ctr[i] = 2'b00;
      end
      // Random parcels, about half forced to 4-byte encodings
      for (int i = 0; i < (1 << MEM_AW); i++) begin
         for (int j = 0; j < 2; j++) begin
            prog[i][16*j +: 16] = rand_bits(16);
            if (rand_bits(1) == 1) begin
               prog[i][16*j +: 2] = 2'b11;
            end
         end
         i_mem.mem[i] = prog[i];
      end

      // Quiet through reset, then plain in-order stream
      wait_cnt = 0;
      do begin
         @(negedge clk);
         check_flag("ifu_i0_valid", ifu_i0_valid, 1'b0);
         check_flag("ifu_i0_bp_taken", ifu_i0_bp_taken, 1'b0);
         if (wait_cnt < RST_CYCLES - 1) begin  // Falling edges well inside reset
            check_flag("iccm_rden", iccm_rden, 1'b0);
         end
         wait_cnt = wait_cnt + 1;
         if (wait_cnt > 50) begin
            stop_on_error("reset was not released within 50 cycles");
         end
      end while (rst_n !== 1'b1);
      run_stream(40, 0);

      run_stream(80, 2);                        // Decode back-pressure

      for (int i = 0; i < 6; i++) begin         // Flushes, even and odd paths
         run_stream(4 + int'(rand_bits(4)), 1);
         flush_to(pc_t'(rand_bits(MEM_AW + 1)), 1'b0);
      end
      run_stream(20, 1);

      // Train a loop branch, then remove it again
      halt_quiet(4);
      dec_tlu_bpred_disable = 1'b0;
      loop_pc = pc_t'(rand_bits(MEM_AW) << 1);
      pick_branch(loop_pc, site, site4);
      retire(site, site4, 1'b1, loop_pc);
      flush_to(loop_pc, 1'b0);
      run_stream(40, 1);
      if (taken_seen < 2) begin
         stop_on_error("trained branch was not predicted taken on later visits");
      end
      halt_quiet(4);
      retire(site, site4, 1'b0, loop_pc);
      retire(site, site4, 1'b0, loop_pc);
      flush_to(loop_pc, 1'b0);
      run_stream(30, 1);

      // Trained entry with prediction off
      halt_quiet(4);
      loop_pc = pc_t'(rand_bits(MEM_AW) << 1);
      pick_branch(loop_pc, site, site4);
      retire(site, site4, 1'b1, loop_pc);
      retire(site, site4, 1'b1, loop_pc);
      dec_tlu_bpred_disable = 1'b1;
      flush_to(loop_pc, 1'b0);
      run_stream(30, 1);
      halt_quiet(4);
      retire(site, site4, 1'b0, loop_pc);
      retire(site, site4, 1'b0, loop_pc);
      dec_tlu_bpred_disable = 1'b0;

      // Parked fetch, then back on a redirect
      flush_to(pc_t'(rand_bits(MEM_AW + 1)), 1'b0);
      run_stream(15, 1);
      halt_quiet(20);
      flush_to(pc_t'(rand_bits(MEM_AW + 1)), 1'b0);
      run_stream(30, 2);

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

//--- compile.f
hw/ifu_pkg.sv
hw/ifu_fetch_ctl.sv
hw/ifu_bp_ctl.sv
hw/ifu_aln_ctl.sv
hw/ifu.sv
dv/ifu_clk_gen.sv
dv/ifu_tb_mem.sv
dv/ifu_tb.sv
